// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_pipe_core
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== access_stage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module access_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 acc_valid,
    input  rv_isa_pkg::reg_idx_t acc_rd,
    input  pipe_pkg::wb_src_e    acc_wb_src,
    input  logic [`XLEN-1:0]     acc_result,
    input  logic [`XLEN-1:0]     acc_store_data,
    input  logic                 acc_is_store,
    output logic                 mem_busy,
    output logic [`XLEN-1:0]     acc_fwd_data,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [`XLEN-1:0]     wb_adr,
    output logic [`XLEN-1:0]     wb_dat_w,
    output logic [`XLEN/8-1:0]   wb_sel,
    input  logic [`XLEN-1:0]     wb_dat_r,
    input  logic                 wb_ack,
    output logic                 ret_valid,
    output rv_isa_pkg::reg_idx_t ret_rd,
    output logic [`XLEN-1:0]     ret_data
);

import pipe_pkg::*;

logic is_load;
logic mem_op;

assign is_load = acc_valid && (acc_wb_src == wb_mem);
assign mem_op  = is_load || (acc_valid && acc_is_store);

// The acc registers are frozen by mem_busy, so the bus request holds until ack.
assign wb_cyc   = mem_op;
assign wb_stb   = mem_op;
assign wb_we    = acc_is_store;
assign wb_adr   = acc_result;
assign wb_dat_w = acc_store_data;
assign wb_sel   = '1; // Word access only.

assign mem_busy = mem_op && !wb_ack;

assign acc_fwd_data = (acc_wb_src == wb_mem) ? wb_dat_r : acc_result;

// Register file write port.
assign ret_valid = acc_valid && (acc_rd != '0) &&
                   ((acc_wb_src == wb_alu) || (is_load && wb_ack));
assign ret_rd    = acc_rd;
assign ret_data  = acc_fwd_data;

a_wb_hold: assert property (@(posedge clk) disable iff (rst)
    wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we));

endmodule

// ==== core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data and address width.
`define XLEN 32

// Architectural integer registers.
`define NREGS 32

// First fetch address after reset.
`define RESET_PC 32'h0000_0000

`endif

// ==== decode_stage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`XLEN-1:0]     instr,
    input  logic [`XLEN-1:0]     pc,
    input  logic                 hold,
    input  logic                 stall,
    output rv_isa_pkg::reg_idx_t rs1,
    output rv_isa_pkg::reg_idx_t rs2,
    output logic                 use_rs1,
    output logic                 use_rs2,
    input  logic [`XLEN-1:0]     rdata1,
    input  logic [`XLEN-1:0]     rdata2,
    input  pipe_pkg::fwd_src_e   fwd_a,
    input  pipe_pkg::fwd_src_e   fwd_b,
    input  logic [`XLEN-1:0]     exe_fwd_data,
    input  logic [`XLEN-1:0]     acc_fwd_data,
    output logic                 exe_valid,
    output rv_isa_pkg::reg_idx_t exe_rd,
    output pipe_pkg::wb_src_e    exe_wb_src,
    output rv_isa_pkg::alu_op_e  exe_alu_op,
    output logic [`XLEN-1:0]     exe_a,
    output logic [`XLEN-1:0]     exe_b,
    output logic [`XLEN-1:0]     exe_store_data,
    output logic                 exe_is_store
);

import rv_isa_pkg::*;
import pipe_pkg::*;

opcode_e          opcode;
funct3_e          funct3;
reg_idx_t         rd;
logic [`XLEN-1:0] imm_i;
logic [`XLEN-1:0] imm_s;
logic [`XLEN-1:0] imm_u;
logic [`XLEN-1:0] op_a;
logic [`XLEN-1:0] op_b;
logic [`XLEN-1:0] dec_a;
logic [`XLEN-1:0] dec_b;
alu_op_e          dec_alu_op;
wb_src_e          dec_wb_src;
logic             dec_is_store;

// Bit 30 selects SUB for OP and SRA for both OP and OP-IMM.
function automatic alu_op_e alu_decode(funct3_e f3, logic alt, logic is_reg);
    case (f3)
        f3_add:     return (alt && is_reg) ? alu_sub : alu_add;
        f3_sll:     return alu_sll;
        f3_slt:     return alu_slt;
        f3_sltu:    return alu_sltu;
        f3_xor:     return alu_xor;
        f3_srl_sra: return alt ? alu_sra : alu_srl;
        f3_or:      return alu_or;
        default:    return alu_and;
    endcase
endfunction

assign opcode = opcode_e'(instr[6:0]);
assign funct3 = funct3_e'(instr[14:12]);
assign rd     = instr[11:7];
assign rs1    = instr[19:15];
assign rs2    = instr[24:20];

assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
assign imm_u = {instr[31:12], 12'b0};

assign use_rs1 = opcode inside {opc_op_imm, opc_op, opc_load, opc_store};
assign use_rs2 = opcode inside {opc_op, opc_store};

always_comb begin
    case (fwd_a)
        fwd_exe: op_a = exe_fwd_data;
        fwd_acc: op_a = acc_fwd_data;
        default: op_a = rdata1;
    endcase
    case (fwd_b)
        fwd_exe: op_b = exe_fwd_data;
        fwd_acc: op_b = acc_fwd_data;
        default: op_b = rdata2;
    endcase
end

always_comb begin
    dec_a        = op_a;
    dec_b        = imm_i;
    dec_alu_op   = alu_add;
    dec_wb_src   = wb_none; // Unknown opcodes retire as no-ops.
    dec_is_store = 1'b0;
    case (opcode)
        opc_lui: begin
            dec_b      = imm_u;
            dec_alu_op = alu_pass_b;
            dec_wb_src = wb_alu;
        end
        opc_auipc: begin
            dec_a      = pc;
            dec_b      = imm_u;
            dec_wb_src = wb_alu;
        end
        opc_op_imm: begin
            dec_alu_op = alu_decode(funct3, instr[30], 1'b0);
            dec_wb_src = wb_alu;
        end
        opc_op: begin
            dec_b      = op_b;
            dec_alu_op = alu_decode(funct3, instr[30], 1'b1);
            dec_wb_src = wb_alu;
        end
        opc_load:  dec_wb_src = wb_mem;
        opc_store: begin
            dec_b        = imm_s;
            dec_is_store = 1'b1;
        end
        default: ;
    endcase
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        exe_valid    <= 1'b0;
        exe_wb_src   <= wb_none;
        exe_is_store <= 1'b0;
    end else if (!hold) begin
        exe_valid    <= !stall; // Bubble on load-use.
        exe_wb_src   <= stall ? wb_none : dec_wb_src;
        exe_is_store <= !stall && dec_is_store;
    end
end

always_ff @(posedge clk) begin
    if (!hold) begin
        exe_rd         <= rd;
        exe_alu_op     <= dec_alu_op;
        exe_a          <= dec_a;
        exe_b          <= dec_b;
        exe_store_data <= op_b;
    end
end

// A load-use stall lasts exactly one cycle.
a_stall_once: assert property (@(posedge clk) disable iff (rst)
    stall && !hold |=> !stall);

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hold,
    input  logic                 exe_valid,
    input  rv_isa_pkg::reg_idx_t exe_rd,
    input  pipe_pkg::wb_src_e    exe_wb_src,
    input  rv_isa_pkg::alu_op_e  exe_alu_op,
    input  logic [`XLEN-1:0]     exe_a,
    input  logic [`XLEN-1:0]     exe_b,
    input  logic [`XLEN-1:0]     exe_store_data,
    input  logic                 exe_is_store,
    output logic [`XLEN-1:0]     exe_fwd_data,
    output logic                 acc_valid,
    output rv_isa_pkg::reg_idx_t acc_rd,
    output pipe_pkg::wb_src_e    acc_wb_src,
    output logic [`XLEN-1:0]     acc_result,
    output logic [`XLEN-1:0]     acc_store_data,
    output logic                 acc_is_store
);

import rv_isa_pkg::*;
import pipe_pkg::*;

logic [$clog2(`XLEN)-1:0] shamt;
logic [`XLEN-1:0]         alu_out;

assign shamt = exe_b[$clog2(`XLEN)-1:0];

always_comb begin
    case (exe_alu_op)
        alu_add:    alu_out = exe_a + exe_b;
        alu_sub:    alu_out = exe_a - exe_b;
        alu_sll:    alu_out = exe_a << shamt;
        alu_slt:    alu_out = {{(`XLEN-1){1'b0}}, $signed(exe_a) < $signed(exe_b)};
        alu_sltu:   alu_out = {{(`XLEN-1){1'b0}}, exe_a < exe_b};
        alu_xor:    alu_out = exe_a ^ exe_b;
        alu_srl:    alu_out = exe_a >> shamt;
        alu_sra:    alu_out = $unsigned($signed(exe_a) >>> shamt);
        alu_or:     alu_out = exe_a | exe_b;
        alu_and:    alu_out = exe_a & exe_b;
        alu_pass_b: alu_out = exe_b;
        default:    alu_out = exe_a + exe_b;
    endcase
end

assign exe_fwd_data = alu_out; // Address for loads and stores.

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        acc_valid    <= 1'b0;
        acc_wb_src   <= wb_none;
        acc_is_store <= 1'b0;
    end else if (!hold) begin
        acc_valid    <= exe_valid;
        acc_wb_src   <= exe_wb_src;
        acc_is_store <= exe_is_store;
    end
end

always_ff @(posedge clk) begin
    if (!hold) begin
        acc_rd         <= exe_rd;
        acc_result     <= alu_out;
        acc_store_data <= exe_store_data;
    end
end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    input  logic                 use_rs1,
    input  logic                 use_rs2,
    input  logic                 exe_valid,
    input  rv_isa_pkg::reg_idx_t exe_rd,
    input  pipe_pkg::wb_src_e    exe_wb_src,
    input  logic                 acc_valid,
    input  rv_isa_pkg::reg_idx_t acc_rd,
    input  pipe_pkg::wb_src_e    acc_wb_src,
    output pipe_pkg::fwd_src_e   fwd_a,
    output pipe_pkg::fwd_src_e   fwd_b,
    output logic                 stall
);

import rv_isa_pkg::*;
import pipe_pkg::*;

logic exe_hit_a;
logic exe_hit_b;
logic acc_hit_a;
logic acc_hit_b;
logic exe_load;

// A producer only matches if it really writes a register.
function automatic logic producer_match(reg_idx_t rs, logic used, logic valid,
                                        reg_idx_t rd, wb_src_e src);
    return used && (rs != '0) && valid && (src != wb_none) && (rd == rs);
endfunction

// The younger stage wins. A load in exe gives no value yet.
function automatic fwd_src_e pick_source(logic exe_hit, logic acc_hit, logic exe_is_load);
    if (exe_hit) begin
        return exe_is_load ? fwd_rf : fwd_exe;
    end else if (acc_hit) begin
        return fwd_acc;
    end
    return fwd_rf;
endfunction

assign exe_load  = (exe_wb_src == wb_mem);

assign exe_hit_a = producer_match(rs1, use_rs1, exe_valid, exe_rd, exe_wb_src);
assign exe_hit_b = producer_match(rs2, use_rs2, exe_valid, exe_rd, exe_wb_src);
assign acc_hit_a = producer_match(rs1, use_rs1, acc_valid, acc_rd, acc_wb_src);
assign acc_hit_b = producer_match(rs2, use_rs2, acc_valid, acc_rd, acc_wb_src);

assign fwd_a = pick_source(exe_hit_a, acc_hit_a, exe_load);
assign fwd_b = pick_source(exe_hit_b, acc_hit_b, exe_load);

assign stall = exe_load && (exe_hit_a || exe_hit_b); // Load-use bubble.

endmodule

// ==== pipe_core.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module pipe_core (
    input  logic                 clk,
    input  logic                 rst,
    output logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     instr,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output logic [`XLEN-1:0]     wb_adr,
    output logic [`XLEN-1:0]     wb_dat_w,
    output logic [`XLEN/8-1:0]   wb_sel,
    input  logic [`XLEN-1:0]     wb_dat_r,
    input  logic                 wb_ack,
    output logic                 ret_valid,
    output rv_isa_pkg::reg_idx_t ret_rd,
    output logic [`XLEN-1:0]     ret_data
);

import rv_isa_pkg::*;
import pipe_pkg::*;

reg_idx_t         rs1;
reg_idx_t         rs2;
logic             use_rs1;
logic             use_rs2;
logic [`XLEN-1:0] rdata1;
logic [`XLEN-1:0] rdata2;
fwd_src_e         fwd_a;
fwd_src_e         fwd_b;
logic             stall;
logic             mem_busy;
logic             exe_valid;
reg_idx_t         exe_rd;
wb_src_e          exe_wb_src;
alu_op_e          exe_alu_op;
logic [`XLEN-1:0] exe_a;
logic [`XLEN-1:0] exe_b;
logic [`XLEN-1:0] exe_store_data;
logic             exe_is_store;
logic [`XLEN-1:0] exe_fwd_data;
logic             acc_valid;
reg_idx_t         acc_rd;
wb_src_e          acc_wb_src;
logic [`XLEN-1:0] acc_result;
logic [`XLEN-1:0] acc_store_data;
logic             acc_is_store;
logic [`XLEN-1:0] acc_fwd_data;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        pc <= `RESET_PC;
    end else if (!stall && !mem_busy) begin
        pc <= pc + 'd4; // No jumps, so fetch is strictly sequential.
    end
end

regfile i_regfile (
    .clk    (clk),
    .rst    (rst),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (ret_valid),
    .rd     (ret_rd),
    .wdata  (ret_data)
);

hazard_unit i_hazard (
    .rs1        (rs1),
    .rs2        (rs2),
    .use_rs1    (use_rs1),
    .use_rs2    (use_rs2),
    .exe_valid  (exe_valid),
    .exe_rd     (exe_rd),
    .exe_wb_src (exe_wb_src),
    .acc_valid  (acc_valid),
    .acc_rd     (acc_rd),
    .acc_wb_src (acc_wb_src),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .stall      (stall)
);

decode_stage i_decode (
    .clk            (clk),
    .rst            (rst),
    .instr          (instr),
    .pc             (pc),
    .hold           (mem_busy),
    .stall          (stall),
    .rs1            (rs1),
    .rs2            (rs2),
    .use_rs1        (use_rs1),
    .use_rs2        (use_rs2),
    .rdata1         (rdata1),
    .rdata2         (rdata2),
    .fwd_a          (fwd_a),
    .fwd_b          (fwd_b),
    .exe_fwd_data   (exe_fwd_data),
    .acc_fwd_data   (acc_fwd_data),
    .exe_valid      (exe_valid),
    .exe_rd         (exe_rd),
    .exe_wb_src     (exe_wb_src),
    .exe_alu_op     (exe_alu_op),
    .exe_a          (exe_a),
    .exe_b          (exe_b),
    .exe_store_data (exe_store_data),
    .exe_is_store   (exe_is_store)
);

execute_stage i_execute (
    .clk            (clk),
    .rst            (rst),
    .hold           (mem_busy),
    .exe_valid      (exe_valid),
    .exe_rd         (exe_rd),
    .exe_wb_src     (exe_wb_src),
    .exe_alu_op     (exe_alu_op),
    .exe_a          (exe_a),
    .exe_b          (exe_b),
    .exe_store_data (exe_store_data),
    .exe_is_store   (exe_is_store),
    .exe_fwd_data   (exe_fwd_data),
    .acc_valid      (acc_valid),
    .acc_rd         (acc_rd),
    .acc_wb_src     (acc_wb_src),
    .acc_result     (acc_result),
    .acc_store_data (acc_store_data),
    .acc_is_store   (acc_is_store)
);

access_stage i_access (
    .clk            (clk),
    .rst            (rst),
    .acc_valid      (acc_valid),
    .acc_rd         (acc_rd),
    .acc_wb_src     (acc_wb_src),
    .acc_result     (acc_result),
    .acc_store_data (acc_store_data),
    .acc_is_store   (acc_is_store),
    .mem_busy       (mem_busy),
    .acc_fwd_data   (acc_fwd_data),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_sel         (wb_sel),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .ret_valid      (ret_valid),
    .ret_rd         (ret_rd),
    .ret_data       (ret_data)
);

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // Where a decode operand is taken from.
    typedef enum logic [1:0] {
        fwd_rf  = 2'd0,
        fwd_exe = 2'd1,
        fwd_acc = 2'd2
    } fwd_src_e;

    // What an instruction writes back to the register file.
    typedef enum logic [1:0] {
        wb_none = 2'd0,
        wb_alu  = 2'd1,
        wb_mem  = 2'd2
    } wb_src_e;

endpackage

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_isa_pkg::reg_idx_t rs1,
    input  rv_isa_pkg::reg_idx_t rs2,
    output logic [`XLEN-1:0]     rdata1,
    output logic [`XLEN-1:0]     rdata2,
    input  logic                 we,
    input  rv_isa_pkg::reg_idx_t rd,
    input  logic [`XLEN-1:0]     wdata
);

logic [`XLEN-1:0] regs [`NREGS];

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        for (int i = 0; i < `NREGS; i++) begin
            regs[i] <= '0;
        end
    end else if (we && rd != '0) begin // x0 is never written.
        regs[rd] <= wdata;
    end
end

assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== rv_isa_pkg.sv ====
`include "core_settings.svh"

package rv_isa_pkg;

    // Major opcodes handled by the pipeline.
    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_e;

    // Integer funct3 field for OP and OP-IMM.
    typedef enum logic [2:0] {
        f3_add     = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10 // LUI passes the immediate through.
    } alu_op_e;

    typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;

endpackage

// ==== src.f ====
+incdir+.
rv_isa_pkg.sv
pipe_pkg.sv
regfile.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
access_stage.sv
pipe_core.sv
tb_pipe_core.sv

// ==== tb_pipe_core.sv ====
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_pipe_core;

import rv_isa_pkg::*;

localparam int PROG_MAX  = 64;
localparam int MEM_WORDS = 64;
localparam int TIMEOUT   = 2000;

localparam logic [`XLEN-1:0] NOP       = 32'h0000_0013; // addi x0, x0, 0
localparam logic [`XLEN-1:0] IDLE_DATA = 32'hDEAD_BEEF;

localparam logic [6:0] OPC_LUI   = 7'b0110111;
localparam logic [6:0] OPC_AUIPC = 7'b0010111;
localparam logic [6:0] OPC_IMM   = 7'b0010011;
localparam logic [6:0] OPC_OP    = 7'b0110011;
localparam logic [6:0] OPC_LOAD  = 7'b0000011;
localparam logic [6:0] OPC_STORE = 7'b0100011;

logic                 clk = 1'b0;
logic                 rst;
logic [`XLEN-1:0]     pc;
logic [`XLEN-1:0]     instr;
logic [`XLEN-1:0]     rom_addr;
logic                 wb_cyc;
logic                 wb_stb;
logic                 wb_we;
logic [`XLEN-1:0]     wb_adr;
logic [`XLEN-1:0]     wb_dat_w;
logic [`XLEN/8-1:0]   wb_sel;
logic [`XLEN-1:0]     wb_dat_r = IDLE_DATA;
logic                 wb_ack = 1'b0;
logic                 ret_valid;
reg_idx_t             ret_rd;
logic [`XLEN-1:0]     ret_data;

logic [`XLEN-1:0] prog [PROG_MAX];
int               prog_len;
logic [`XLEN-1:0] mem [MEM_WORDS];
reg_idx_t         exp_rd [$];
logic [`XLEN-1:0] exp_data [$];
logic [`XLEN-1:0] exp_adr [$];
logic [`XLEN-1:0] exp_dat [$];
int               exp_xfers;
int               xfer_count = 0;
int               seed = 32'h2601_10d0;
int               ack_delay;
int               wait_left;
logic             armed;
int               mismatch_count = 0;
int               fail_count = 0;
int               cycles;

always #10 clk = ~clk;

pipe_core i_dut (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .instr     (instr),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_sel    (wb_sel),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .ret_valid (ret_valid),
    .ret_rd    (ret_rd),
    .ret_data  (ret_data)
);

// Instruction ROM, answered in the same cycle.
assign rom_addr = pc - `RESET_PC;
assign instr    = (rom_addr[31:8] == '0) ? prog[rom_addr[7:2]] : NOP;

function automatic logic [`XLEN-1:0] fill_word(int idx);
    return 32'hC0DE_0000 ^ (idx * 32'h0001_0041);
endfunction

function automatic logic [`XLEN-1:0] op_imm(int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OPC_IMM};
endfunction

function automatic logic [`XLEN-1:0] op_reg(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
endfunction

function automatic logic [`XLEN-1:0] load_word(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
endfunction

function automatic logic [`XLEN-1:0] store_word(int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [`XLEN-1:0] upper(logic [6:0] opc, int rd, int imm);
    return {imm[19:0], rd[4:0], opc};
endfunction

// RV32I integer rules for OP and OP-IMM.
function automatic logic [`XLEN-1:0] alu_ref(logic [2:0] f3, logic alt, logic is_reg,
                                             logic [`XLEN-1:0] a, logic [`XLEN-1:0] b);
    case (f3)
        3'd0:    return (alt && is_reg) ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic add_to_rom(logic [`XLEN-1:0] word);
    prog[prog_len] = word;
    prog_len++;
endtask

task automatic load_program();
    for (int i = 0; i < PROG_MAX; i++) begin
        prog[i] = NOP;
    end
    prog_len = 0;
    add_to_rom(upper(OPC_LUI, 1, 'h12345));
    add_to_rom(upper(OPC_AUIPC, 2, 'h00001));
    add_to_rom(op_imm(0, 3, 1, 'h7ff));     // x1 two slots back.
    add_to_rom(op_imm(0, 4, 3, -16));
    add_to_rom(op_reg(0, 0, 5, 4, 4));      // Both sources from exe.
    add_to_rom(op_reg('h20, 0, 6, 3, 5));   // Negative result.
    add_to_rom(op_imm(0, 7, 0, 11));
    add_to_rom(op_imm(0, 7, 0, 22));
    add_to_rom(op_reg(0, 0, 8, 7, 7));      // Exe and acc both hold x7.
    add_to_rom(op_imm(0, 0, 5, 123));
    add_to_rom(op_reg(0, 0, 9, 0, 6));
    add_to_rom(op_reg(0, 0, 10, 0, 0));
    add_to_rom(op_imm(2, 11, 6, -1));
    add_to_rom(op_imm(3, 12, 6, -1));
    add_to_rom(op_imm(4, 13, 1, 'h5a5));
    add_to_rom(op_imm(6, 14, 13, 'h0f0));
    add_to_rom(op_imm(7, 15, 14, 'h3c3));
    add_to_rom(op_imm(1, 16, 1, 4));
    add_to_rom(op_imm(5, 17, 6, 3));
    add_to_rom(op_imm(5, 18, 6, 'h403));    // srai
    add_to_rom(op_reg(0, 1, 19, 1, 17));
    add_to_rom(op_reg(0, 2, 20, 6, 1));
    add_to_rom(op_reg(0, 3, 21, 6, 1));
    add_to_rom(op_reg(0, 4, 22, 16, 18));
    add_to_rom(op_reg(0, 5, 23, 18, 3));
    add_to_rom(op_reg('h20, 5, 24, 6, 3));
    add_to_rom(op_reg(0, 6, 25, 22, 23));
    add_to_rom(op_reg(0, 7, 26, 25, 1));
    add_to_rom(op_imm(0, 27, 0, 64));
    add_to_rom(store_word(5, 27, 0));
    add_to_rom(store_word(8, 27, 4));
    add_to_rom(load_word(28, 27, 0));
    add_to_rom(op_reg(0, 0, 29, 28, 1));    // Load-use.
    add_to_rom(load_word(30, 27, 4));
    add_to_rom(load_word(31, 27, 8));       // Never stored.
    add_to_rom(op_reg(0, 0, 29, 30, 31));
    add_to_rom(store_word(29, 27, -4));
    add_to_rom(load_word(0, 27, -4));
    add_to_rom(load_word(11, 27, -4));
    add_to_rom(op_imm(0, 12, 11, 1));
    add_to_rom(op_reg(0, 4, 13, 11, 12));
    add_to_rom(32'h0000_006F);              // JAL is not supported.
    add_to_rom(32'h0000_000F);              // FENCE is not supported.
    add_to_rom(op_reg(0, 0, 14, 13, 12));
endtask

// Walks the program in order and queues the expected retirements and writes.
task automatic build_expected();
    logic [`XLEN-1:0] regs [`NREGS];
    logic [`XLEN-1:0] gmem [MEM_WORDS];
    logic [`XLEN-1:0] ins;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] value;
    logic             writes;
    reg_idx_t         rd;
    exp_xfers = 0;
    for (int r = 0; r < `NREGS; r++) begin
        regs[r] = '0;
    end
    for (int w = 0; w < MEM_WORDS; w++) begin
        gmem[w] = fill_word(w);
    end
    for (int i = 0; i < prog_len; i++) begin
        ins    = prog[i];
        rd     = ins[11:7];
        a      = regs[ins[19:15]];
        b      = regs[ins[24:20]];
        imm_i  = {{(`XLEN-12){ins[31]}}, ins[31:20]};
        writes = 1'b1;
        value  = '0;
        case (ins[6:0])
            OPC_LUI:   value = {ins[31:12], 12'b0};
            OPC_AUIPC: value = `RESET_PC + 4 * i + {ins[31:12], 12'b0};
            OPC_IMM:   value = alu_ref(ins[14:12], ins[30], 1'b0, a, imm_i);
            OPC_OP:    value = alu_ref(ins[14:12], ins[30], 1'b1, a, b);
            OPC_LOAD: begin
                addr  = a + imm_i;
                value = gmem[addr[7:2]];
                exp_xfers++;
            end
            OPC_STORE: begin
                addr = a + {{(`XLEN-12){ins[31]}}, ins[31:25], ins[11:7]};
                gmem[addr[7:2]] = b;
                exp_adr.push_back(addr);
                exp_dat.push_back(b);
                exp_xfers++;
                writes = 1'b0;
            end
            default:   writes = 1'b0;
        endcase
        if (writes && rd != 0) begin
            regs[rd] = value;
            exp_rd.push_back(rd);
            exp_data.push_back(value);
        end
    end
endtask

task automatic check_ret(reg_idx_t rd_got, logic [`XLEN-1:0] data_got);
    reg_idx_t         want_rd;
    logic [`XLEN-1:0] want_data;
    if (exp_rd.size() == 0) begin
        $display("Unexpected retirement of x%0d at %0t", rd_got, $time);
        fail_count++;
    end else begin
        want_rd   = exp_rd.pop_front();
        want_data = exp_data.pop_front();
        if (rd_got !== want_rd) begin
            $display("MISMATCH ret_rd: got %h, expected %h at %0t", rd_got, want_rd, $time);
            mismatch_count++;
        end
        if (data_got !== want_data) begin
            $display("MISMATCH ret_data: got %h, expected %h at %0t",
                     data_got, want_data, $time);
            mismatch_count++;
        end
    end
endtask

task automatic check_bus(logic [`XLEN-1:0] adr, logic [`XLEN-1:0] dat,
                         logic [`XLEN/8-1:0] sel);
    logic [`XLEN-1:0] want_adr;
    logic [`XLEN-1:0] want_dat;
    if (exp_adr.size() == 0) begin
        $display("Unexpected Wishbone write to %h at %0t", adr, $time);
        fail_count++;
    end else begin
        want_adr = exp_adr.pop_front();
        want_dat = exp_dat.pop_front();
        if (adr !== want_adr) begin
            $display("MISMATCH wb_adr: got %h, expected %h at %0t", adr, want_adr, $time);
            mismatch_count++;
        end
        if (dat !== want_dat) begin
            $display("MISMATCH wb_dat_w: got %h, expected %h at %0t", dat, want_dat, $time);
            mismatch_count++;
        end
        if (sel !== '1) begin
            $display("MISMATCH wb_sel: got %h, expected %h at %0t", sel, 4'hf, $time);
            mismatch_count++;
        end
    end
endtask

task automatic check_flag(string name, logic got, logic want);
    if (got !== want) begin
        $display("MISMATCH %s: got %h, expected %h at %0t", name, got, want, $time);
        mismatch_count++;
    end
endtask

task automatic check_pc(logic [`XLEN-1:0] got, logic [`XLEN-1:0] want);
    if (got !== want) begin
        $display("MISMATCH pc: got %h, expected %h at %0t", got, want, $time);
        mismatch_count++;
    end
endtask

task automatic check_count(string name, int got, int want);
    if (got != want) begin
        $display("MISMATCH %s: got %h, expected %h at %0t", name, got, want, $time);
        mismatch_count++;
    end
endtask

// Wishbone slave with a random ack delay.
always @(posedge clk) begin
    if (rst) begin
        wb_ack    <= 1'b0;
        wb_dat_r  <= IDLE_DATA;
        armed     <= 1'b0;
        wait_left <= 0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem[w] <= fill_word(w);
        end
    end else if (wb_ack) begin
        wb_ack   <= 1'b0; // Transfer ends in the ack cycle.
        wb_dat_r <= IDLE_DATA;
        armed    <= 1'b0;
        if (wb_we) begin
            mem[wb_adr[7:2]] <= wb_dat_w;
        end
    end else if (wb_cyc && wb_stb) begin
        if (!armed) begin
            ack_delay = $unsigned($random(seed)) % 4;
            armed <= 1'b1;
            if (ack_delay == 0) begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[wb_adr[7:2]];
            end else begin
                wait_left <= ack_delay - 1;
            end
        end else if (wait_left == 0) begin
            wb_ack   <= 1'b1;
            wb_dat_r <= mem[wb_adr[7:2]];
        end else begin
            wait_left <= wait_left - 1;
        end
    end
end

// Outputs are sampled half a cycle after the edge.
always @(negedge clk) begin
    if (!rst) begin
        if (ret_valid) begin
            check_ret(ret_rd, ret_data);
        end
        if (wb_cyc && wb_stb && wb_ack) begin
            xfer_count++;
            if (wb_adr[31:8] != 0 || wb_adr[1:0] != 0) begin
                $display("Wishbone address %h is outside the test memory at %0t",
                         wb_adr, $time);
                fail_count++;
            end
            if (wb_we) begin
                check_bus(wb_adr, wb_dat_w, wb_sel);
            end
        end
    end
end

initial begin
    rst = 1'b1;
    load_program();
    build_expected();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_pc(pc, `RESET_PC);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("wb_stb", wb_stb, 1'b0);
    check_flag("ret_valid", ret_valid, 1'b0);
    cycles = 0;
    while ((exp_rd.size() != 0 || exp_adr.size() != 0) && cycles < TIMEOUT) begin
        @(posedge clk);
        cycles++;
    end
    if (cycles >= TIMEOUT) begin
        $display("Timeout after %0d cycles with %0d retirements and %0d writes outstanding",
                 cycles, exp_rd.size(), exp_adr.size());
        fail_count++;
    end
    for (int i = 0; i < 16; i++) begin
        @(posedge clk); // Tail of no-ops must not retire.
    end
    check_count("wishbone transfers", xfer_count, exp_xfers);
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) begin
        $display("No errors");
    end else begin
        $display("Errors found");
    end
    $finish;
end

endmodule
